// File: verif/legPatterns.hex
// mode instruction resWrite result flags
// Mode 0 idles one cycle first, 1 issues back to back, 2 pulses reset
0 E3A010FF 1 000000FF 0
1 E3B024FF 1 FF000000 A
0 E3B03000 1 00000000 6
0 E3E04102 1 7FFFFFFF 6
0 E0945001 1 800000FE 9
0 E0536001 1 FFFFFF01 8
1 E0767001 1 000001FE 0
0 E1720002 0 FE000000 A
1 E0B18001 1 000001FF 0
0 E0D19001 1 FFFFFFFF 8
0 E1540002 0 80FFFFFF 9
0 E031B082 1 FE0000FF B
0 E1D9C422 1 FF00FFFF 9
0 E1B0D022 1 00000000 7
0 E1F0E242 1 000FFFFF 1
0 E1150046 0 800000FE B
0 E1B0A061 1 8000007F B
0 E13100E7 0 00000000 5
0 13A00001 0 00000001 5
0 33A00002 1 00000002 5
1 63A00003 1 00000003 5
0 A1510001 0 00000000 5
0 B1510001 0 00000000 6
1 03A00006 1 00000006 6
0 83A00007 0 00000007 6
0 23A00008 1 00000008 6
0 41530001 0 FFFFFF01 6
0 51530001 0 FFFFFF01 8
1 73A0000B 1 0000000B 8
0 C3A0000C 0 0000000C 8
0 91720002 0 FE000000 A
1 83A0000E 1 0000000E A
0 F3A0000F 0 0000000F A
0 D3A00010 1 00000010 A
2 00000000 0 00000000 0
0 E0921009 1 00000000 4

// File: legExecute.f
hw/legPkg.sv
hw/regFile.sv
hw/barrelShifter.sv
hw/aluUnit.sv
hw/conditional.sv
hw/executeStage.sv
verif/executeStageTb.sv

// File: Bender.yml
package:
  name: legExecute

sources:
  - files:
      - hw/legPkg.sv
      - hw/regFile.sv
      - hw/barrelShifter.sv
      - hw/aluUnit.sv
      - hw/conditional.sv
      - hw/executeStage.sv
  - target: test
    files:
      - verif/executeStageTb.sv

// File: verif/executeStageTb.sv
module executeStageTb;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int timeoutCycles = 10;  // Edges to wait for resValid

  logic        clk;
  logic        rst;
  logic        instValid;
  logic [31:0] inst;
  logic        resValid;
  logic        resWrite;
  logic [3:0]  resRd;
  logic [31:0] result;
  logic [3:0]  flags;

  int unsigned lineCount;  // Instructions issued so far

  executeStage dut_i (
    .clk       (clk),
    .rst       (rst),
    .instValid (instValid),
    .inst      (inst),
    .resValid  (resValid),
    .resWrite  (resWrite),
    .resRd     (resRd),
    .result    (result),
    .flags     (flags)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;  // 8 ns period
  end

  // Report the error and stop the run
  task automatic abortRun(input string why);
    $display("%s", why);
    $display("Checks failed");
    $fatal(1, "Run stopped at the first error");
  endtask

  task automatic checkValue(input string name, input logic [31:0] got,
                            input logic [31:0] expected);
    if (got !== expected) begin
      abortRun($sformatf("MISMATCH time %0t signal %s got %h expected %h",
                         $time, name, got, expected));
    end
  endtask

  // Hold reset for two cycles and release just after an edge
  task automatic resetDut();
    rst       = 1'b1;
    instValid = 1'b0;
    repeat (2) @(posedge clk);
    #1;
    rst = 1'b0;
  endtask

  // Strobe one instruction and wait for its result
  task automatic issueInst(input logic [31:0] word);
    int waited;
    waited    = 0;
    inst      = word;
    instValid = 1'b1;
    @(posedge clk);
    #1;
    instValid = 1'b0;  // Next line may raise it again right away
    while (!resValid) begin
      if (waited == timeoutCycles) begin
        abortRun($sformatf("No result within %0d cycles for instruction %h",
                           timeoutCycles, word));
      end
      @(posedge clk);
      #1;
      waited++;
    end
    lineCount++;
  endtask

  initial begin
    int          fd;
    int          fields;
    string       line;
    logic [31:0] mode;
    logic [31:0] word;
    logic [31:0] expWrite;
    logic [31:0] expResult;
    logic [31:0] expFlags;
    rst       = 1'b1;
    instValid = 1'b0;
    inst      = '0;
    lineCount = 0;
    fd = $fopen("verif/legPatterns.hex", "r");
    if (fd == 0) begin
      abortRun("Could not open the pattern file verif/legPatterns.hex");
    end
    resetDut();
    while (!$feof(fd)) begin
      if ($fgets(line, fd) == 0) begin
        break;  // End of file
      end
      if (line.len() < 2 || line.substr(0, 1) == "//") begin
        continue;  // Blank or comment
      end
      fields = $sscanf(line, "%h %h %h %h %h", mode, word, expWrite, expResult, expFlags);
      if (fields != 5) begin
        abortRun($sformatf("Pattern line has %0d fields instead of 5", fields));
      end
      if (mode == 2) begin
        resetDut();  // Mid-run reset
        checkValue("resValid", resValid, 32'd0);
        checkValue("resWrite", resWrite, expWrite);
        checkValue("flags", flags, expFlags);
      end else if (mode < 2) begin
        if (mode == 0) begin
          @(posedge clk);  // One idle cycle
          #1;
          checkValue("resValid", resValid, 32'd0);  // No result without a strobe
        end
        issueInst(word);
        checkValue("resWrite", resWrite, expWrite);
        checkValue("resRd", resRd, word[15:12]);  // Rd field of the instruction
        checkValue("result", result, expResult);
        checkValue("flags", flags, expFlags);
      end else begin
        abortRun($sformatf("Unknown mode %0d in pattern file", mode));
      end
    end
    $fclose(fd);
    if (lineCount == 0) begin
      abortRun("Pattern file held no instructions");
    end else begin
      $display("All checks passed");
      $finish;
    end
  end

endmodule

// File: hw/executeStage.sv
module executeStage (
  input  logic                            clk,
  input  logic                            rst,
  input  logic                            instValid,  // One cycle per instruction
  input  logic [legPkg::dataWidth-1:0]    inst,
  output logic                            resValid,   // Pulses one cycle later
  output logic                            resWrite,
  output logic [legPkg::regAddrWidth-1:0] resRd,
  output logic [legPkg::dataWidth-1:0]    result,
  output logic [3:0]                      flags       // NZCV
);
  import legPkg::*;

  // Instruction fields
  logic [3:0]              cond;
  logic                    immSel;
  logic [3:0]              opcode;
  logic                    setFlags;
  logic [regAddrWidth-1:0] rn;
  logic [regAddrWidth-1:0] rd;
  op2Field                 op2Bits;

  logic [dataWidth-1:0] rnVal;
  logic [dataWidth-1:0] rmVal;
  logic [dataWidth-1:0] op2;
  logic                 shCarry;
  logic [dataWidth-1:0] aluResult;
  logic [3:0]           aluFlags;
  logic                 cvClass;
  logic                 condEx;
  logic [3:0]           flagsNext;
  logic                 opWrites;
  logic                 regWrite;

  assign cond     = inst[31:28];
  assign immSel   = inst[25];  // Bits 27:26 are 00 for data processing
  assign opcode   = inst[24:21];
  assign setFlags = inst[20];
  assign rn       = inst[19:16];
  assign rd       = inst[15:12];
  assign op2Bits  = inst[11:0];

  // Compares and tests only touch flags
  assign opWrites = !(opcode inside {opTst, opTeq, opCmp, opCmn});
  assign regWrite = instValid & condEx & opWrites;

  regFile regFile_i (
    .clk    (clk),
    .rst    (rst),
    .raddrA (rn),
    .raddrB (op2Bits.regForm.rm),
    .rdataA (rnVal),
    .rdataB (rmVal),
    .we     (regWrite),
    .waddr  (rd),
    .wdata  (aluResult)
  );

  barrelShifter barrelShifter_i (
    .op2Bits (op2Bits),
    .immSel  (immSel),
    .rmVal   (rmVal),
    .carryIn (flags[1]),
    .op2     (op2),
    .shCarry (shCarry)
  );

  aluUnit aluUnit_i (
    .opcode    (opcode),
    .rnVal     (rnVal),
    .op2       (op2),
    .carryIn   (flags[1]),
    .aluResult (aluResult),
    .aluFlags  (aluFlags),
    .cvClass   (cvClass)
  );

  conditional conditional_i (
    .cond      (cond),
    .flags     (flags),
    .aluFlags  (aluFlags),
    .shCarry   (shCarry),
    .cvClass   (cvClass),
    .setFlags  (setFlags),
    .condEx    (condEx),
    .flagsNext (flagsNext)
  );

  // Flag register, only an accepted instruction changes it
  always_ff @(posedge clk) begin
    if (rst) begin
      flags <= 4'b0000;
    end else if (instValid) begin
      flags <= flagsNext;
    end
  end

  // Result strobes
  always_ff @(posedge clk) begin
    if (rst) begin
      resValid <= 1'b0;
      resWrite <= 1'b0;
    end else begin
      resValid <= instValid;
      resWrite <= regWrite;  // Zero when idle
    end
  end

  // Payload holds between results
  always_ff @(posedge clk) begin
    if (instValid) begin
      resRd  <= rd;
      result <= aluResult;
    end
  end

endmodule

// File: hw/conditional.sv
module conditional (
  input  logic [3:0] cond,       // inst[31:28]
  input  logic [3:0] flags,      // Current NZCV
  input  logic [3:0] aluFlags,   // NZCV from the ALU
  input  logic       shCarry,    // Shifter carry out
  input  logic       cvClass,    // Logical or arithmetic
  input  logic       setFlags,   // S bit
  output logic       condEx,     // Instruction takes effect
  output logic [3:0] flagsNext
);
  import legPkg::*;

  logic       neg;
  logic       zero;
  logic       carry;
  logic       ovf;
  logic       ge;
  logic       updateFlags;
  logic [1:0] cvNext;

  assign {neg, zero, carry, ovf} = flags;
  assign ge = (neg == ovf);  // Signed greater or equal

  always_comb begin
    case (cond)
      condEq: condEx = zero;
      condNe: condEx = ~zero;
      condCs: condEx = carry;
      condCc: condEx = ~carry;
      condMi: condEx = neg;
      condPl: condEx = ~neg;
      condVs: condEx = ovf;
      condVc: condEx = ~ovf;
      condHi: condEx = carry & ~zero;
      condLs: condEx = ~carry | zero;
      condGe: condEx = ge;
      condLt: condEx = ~ge;
      condGt: condEx = ~zero & ge;
      condLe: condEx = zero | ~ge;
      condAl: condEx = 1'b1;
      condNv: condEx = 1'b0;  // Never executes
    endcase
  end

  // Only a flag-setting instruction that passes its condition
  assign updateFlags = setFlags & condEx;

  // Logical ops keep V and take the shifter's carry
  assign cvNext = (cvClass == cvArith) ? aluFlags[1:0] : {shCarry, ovf};

  assign flagsNext = updateFlags ? {aluFlags[3:2], cvNext} : flags;

endmodule

// File: hw/aluUnit.sv
module aluUnit (
  input  logic [3:0]                   opcode,
  input  logic [legPkg::dataWidth-1:0] rnVal,
  input  logic [legPkg::dataWidth-1:0] op2,
  input  logic                         carryIn,   // C flag for ADC/SBC/RSC
  output logic [legPkg::dataWidth-1:0] aluResult,
  output logic [3:0]                   aluFlags,  // Raw NZCV
  output logic                         cvClass
);
  import legPkg::*;

  logic [dataWidth-1:0] addA;
  logic [dataWidth-1:0] addB;
  logic                 addCin;
  logic [dataWidth:0]   sum;       // Bit 32 is carry out
  logic [dataWidth-1:0] logicRes;
  logic                 useAdder;
  logic                 overflow;
  logic                 zeroFlag;

  // Operand steering for the shared adder
  always_comb begin
    addA     = rnVal;
    addB     = op2;
    addCin   = 1'b0;
    logicRes = op2;
    useAdder = 1'b0;
    case (opcode)
      opAnd, opTst: logicRes = rnVal & op2;
      opEor, opTeq: logicRes = rnVal ^ op2;
      opOrr:        logicRes = rnVal | op2;
      opMov:        logicRes = op2;
      opBic:        logicRes = rnVal & ~op2;
      opMvn:        logicRes = ~op2;
      opSub, opCmp: begin
        // Rn - op2 as Rn + ~op2 + 1
        addB     = ~op2;
        addCin   = 1'b1;
        useAdder = 1'b1;
      end
      opRsb: begin
        addA     = op2;
        addB     = ~rnVal;
        addCin   = 1'b1;
        useAdder = 1'b1;
      end
      opAdd, opCmn: begin
        useAdder = 1'b1;
      end
      opAdc: begin
        addCin   = carryIn;
        useAdder = 1'b1;
      end
      opSbc: begin
        addB     = ~op2;
        addCin   = carryIn;  // Borrow is NOT C
        useAdder = 1'b1;
      end
      opRsc: begin
        addA     = op2;
        addB     = ~rnVal;
        addCin   = carryIn;
        useAdder = 1'b1;
      end
      default: begin
        logicRes = op2;
        useAdder = 1'b0;
      end
    endcase
  end

  assign sum = {1'b0, addA} + {1'b0, addB} + {{dataWidth{1'b0}}, addCin};

  // Signed overflow, same input signs but result sign differs
  assign overflow = (addA[dataWidth-1] == addB[dataWidth-1]) &&
                    (sum[dataWidth-1] != addA[dataWidth-1]);

  assign aluResult = useAdder ? sum[dataWidth-1:0] : logicRes;
  assign zeroFlag  = (aluResult == '0);

  // C is carry out, so 1 means no borrow on subtracts
  assign aluFlags = {aluResult[dataWidth-1], zeroFlag, sum[dataWidth], overflow};
  assign cvClass  = useAdder ? cvArith : cvLogical;

endmodule

// File: hw/barrelShifter.sv
module barrelShifter (
  input  legPkg::op2Field             op2Bits,  // Raw operand 2 field
  input  logic                        immSel,   // I bit, 1 = rotated immediate
  input  logic [legPkg::dataWidth-1:0] rmVal,   // Rm read data
  input  logic                        carryIn,  // Current C flag
  output logic [legPkg::dataWidth-1:0] op2,
  output logic                        shCarry
);
  import legPkg::*;

  logic [dataWidth-1:0]   immExt;
  logic [4:0]             rotAmt;
  logic [2*dataWidth-1:0] immWide;
  logic [dataWidth-1:0]   immRot;
  logic                   immCarry;
  logic [4:0]             shamt;
  logic [1:0]             shType;
  logic signed [dataWidth:0] asrExt;
  logic [2*dataWidth-1:0] rorWide;
  logic [dataWidth-1:0]   regOut;
  logic                   regCarry;

  // Immediate form
  assign immExt  = {{(dataWidth-8){1'b0}}, op2Bits.immForm.imm8};
  assign rotAmt  = {op2Bits.immForm.rot, 1'b0};  // Always even
  assign immWide = {immExt, immExt} >> rotAmt;    // Rotate via doubled word
  assign immRot  = immWide[dataWidth-1:0];
  assign immCarry = (op2Bits.immForm.rot != 4'd0) ? immRot[dataWidth-1] : carryIn;

  // Register form
  assign shamt   = op2Bits.regForm.shamt;
  assign shType  = op2Bits.regForm.shType;
  assign asrExt  = {rmVal, 1'b0};  // Extra LSB catches the carry
  assign rorWide = {rmVal, rmVal} >> shamt;

  always_comb begin
    regOut   = rmVal;
    regCarry = carryIn;
    case (shType)
      shLsl: begin
        if (shamt != 5'd0) begin
          {regCarry, regOut} = {1'b0, rmVal} << shamt;  // Carry is last bit out the top
        end
      end
      shLsr: begin
        if (shamt == 5'd0) begin
          // LSR #32
          regOut   = '0;
          regCarry = rmVal[dataWidth-1];
        end else begin
          {regOut, regCarry} = {rmVal, 1'b0} >> shamt;
        end
      end
      shAsr: begin
        if (shamt == 5'd0) begin
          regOut   = {dataWidth{rmVal[dataWidth-1]}};  // ASR #32, sign fill
          regCarry = rmVal[dataWidth-1];
        end else begin
          {regOut, regCarry} = asrExt >>> shamt;
        end
      end
      shRor: begin
        if (shamt == 5'd0) begin
          // RRX through the old carry
          regOut   = {carryIn, rmVal[dataWidth-1:1]};
          regCarry = rmVal[0];
        end else begin
          regOut   = rorWide[dataWidth-1:0];
          regCarry = rorWide[dataWidth-1];  // Last bit rotated out
        end
      end
      default: begin
        regOut   = rmVal;
        regCarry = carryIn;
      end
    endcase
  end

  assign op2     = immSel ? immRot : regOut;
  assign shCarry = immSel ? immCarry : regCarry;

endmodule

// File: hw/regFile.sv
module regFile (
  input  logic                            clk,
  input  logic                            rst,
  input  logic [legPkg::regAddrWidth-1:0] raddrA,  // Rn port
  input  logic [legPkg::regAddrWidth-1:0] raddrB,  // Rm port
  output logic [legPkg::dataWidth-1:0]    rdataA,
  output logic [legPkg::dataWidth-1:0]    rdataB,
  input  logic                            we,
  input  logic [legPkg::regAddrWidth-1:0] waddr,
  input  logic [legPkg::dataWidth-1:0]    wdata
);
  import legPkg::*;

  localparam int numRegs = 2 ** regAddrWidth;

  logic [dataWidth-1:0] regs [numRegs];

  // All registers clear on reset
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < numRegs; i++) begin
        regs[i] <= '0;
      end
    end else if (we) begin
      regs[waddr] <= wdata;
    end
  end

  // Reads see the old value in the write cycle
  assign rdataA = regs[raddrA];
  assign rdataB = regs[raddrB];

endmodule

// File: hw/legPkg.sv
package legPkg;

  // Datapath and register index widths
  localparam int dataWidth    = 32;
  localparam int regAddrWidth = 4;

  // Condition field encodings, inst[31:28]
  localparam logic [3:0] condEq = 4'b0000;  // Z set
  localparam logic [3:0] condNe = 4'b0001;  // Z clear
  localparam logic [3:0] condCs = 4'b0010;  // C set
  localparam logic [3:0] condCc = 4'b0011;  // C clear
  localparam logic [3:0] condMi = 4'b0100;  // Negative
  localparam logic [3:0] condPl = 4'b0101;  // Positive or zero
  localparam logic [3:0] condVs = 4'b0110;  // Overflow
  localparam logic [3:0] condVc = 4'b0111;  // No overflow
  localparam logic [3:0] condHi = 4'b1000;  // Unsigned higher
  localparam logic [3:0] condLs = 4'b1001;  // Unsigned lower or same
  localparam logic [3:0] condGe = 4'b1010;  // Signed >=
  localparam logic [3:0] condLt = 4'b1011;  // Signed <
  localparam logic [3:0] condGt = 4'b1100;  // Signed >
  localparam logic [3:0] condLe = 4'b1101;  // Signed <=
  localparam logic [3:0] condAl = 4'b1110;  // Always
  localparam logic [3:0] condNv = 4'b1111;  // Never

  // Data-processing opcodes, inst[24:21]
  localparam logic [3:0] opAnd = 4'b0000;
  localparam logic [3:0] opEor = 4'b0001;
  localparam logic [3:0] opSub = 4'b0010;
  localparam logic [3:0] opRsb = 4'b0011;
  localparam logic [3:0] opAdd = 4'b0100;
  localparam logic [3:0] opAdc = 4'b0101;
  localparam logic [3:0] opSbc = 4'b0110;
  localparam logic [3:0] opRsc = 4'b0111;
  localparam logic [3:0] opTst = 4'b1000;  // AND, flags only
  localparam logic [3:0] opTeq = 4'b1001;  // EOR, flags only
  localparam logic [3:0] opCmp = 4'b1010;  // SUB, flags only
  localparam logic [3:0] opCmn = 4'b1011;  // ADD, flags only
  localparam logic [3:0] opOrr = 4'b1100;
  localparam logic [3:0] opMov = 4'b1101;
  localparam logic [3:0] opBic = 4'b1110;
  localparam logic [3:0] opMvn = 4'b1111;

  // Shift types of the register form
  localparam logic [1:0] shLsl = 2'b00;
  localparam logic [1:0] shLsr = 2'b01;
  localparam logic [1:0] shAsr = 2'b10;
  localparam logic [1:0] shRor = 2'b11;

  // How C and V get updated
  localparam logic cvLogical = 1'b0;  // C from shifter, V kept
  localparam logic cvArith   = 1'b1;  // C and V from adder

  // Operand 2 field, inst[11:0], view picked by the I bit
  typedef union packed {
    struct packed {
      logic [3:0] rot;       // Rotate right by 2*rot
      logic [7:0] imm8;
    } immForm;
    struct packed {
      logic [4:0] shamt;
      logic [1:0] shType;
      logic       regShift;  // RSR form, must be 0 here
      logic [3:0] rm;
    } regForm;
  } op2Field;

endpackage
